//--- all.f
+incdir+src
src/cpu7_pkg.sv
src/data_stack.sv
src/core_alu.sv
src/core_seq.sv
src/cpu7_core.sv
sim/core_assert.sv
sim/tb_core.sv

//--- run.sh
#!/bin/sh
# compile and run the cpu7 core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_core -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_core +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
exit 1

//--- sim/core_assert.sv
// bound assertions on the cpu7 core idle, error code and trace outputs

`default_nettype none

`include "cpu7_params.svh"

module core_assert (
	input logic               clk,
	input logic               rst_n,
	input logic               i_en,
	input logic               i_push_en,
	input logic               i_instr_en,
	input cpu7_pkg::errcode_t i_errcode,
	input logic [7:0]         i_trace,
	input logic               i_idle
);

	import cpu7_pkg::*;

	int unsigned fail_count = 0;	// read by the testbench at the end

	// idle and clean right after reset release
	assert property (@(posedge clk) $rose(rst_n) |-> (i_idle && i_errcode == ERR_NONE))
		else begin
			$error("core not idle or error code set in the first cycle after reset");
			fail_count++;
		end

	// a strobe seen while idle and enabled is accepted, so idle drops next cycle
	assert property (@(posedge clk) disable iff (!rst_n)
		($past(i_idle) && i_en && (i_push_en || i_instr_en)) |=> !i_idle)
		else begin
			$error("o_idle still high in the cycle after an accepted strobe");
			fail_count++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		!i_en |=> ($stable(i_trace) && $stable(i_errcode)))
		else begin
			$error("o_trace or o_errcode changed while i_en was low");
			fail_count++;
		end

endmodule

bind cpu7_core core_assert u_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_en       (i_en),
	.i_push_en  (i_push_en),
	.i_instr_en (i_instr_en),
	.i_errcode  (o_errcode),
	.i_trace    (o_trace),
	.i_idle     (o_idle)
);

`default_nettype wire

//--- sim/tb_core.sv
// cpu7 core testbench with clock, reset, stimulus, stack model and output checks

`default_nettype none

`include "cpu7_params.svh"

module tb_core;

	import cpu7_pkg::*;

	localparam int TIMEOUT = 200;	// cycles allowed for one operation

	logic                    clk;
	logic                    rst_n;
	logic                    i_en;
	logic                    i_push_en;
	logic [`CPU7_WORD_W-1:0] i_push_value;
	logic                    i_instr_en;
	instr_pair_t             i_instr;
	errcode_t                o_errcode;
	logic [7:0]              o_trace;
	logic                    o_idle;

	logic [`CPU7_WORD_W-1:0] model_q[$];	// back of the queue is the stack top
	logic [7:0]              exp_trace;
	logic [`CPU7_ERR_W-1:0]  exp_err;
	int                      checks;
	int                      mismatches;
	int                      timeouts;

	cpu7_core DUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_en         (i_en),
		.i_push_en    (i_push_en),
		.i_push_value (i_push_value),
		.i_instr_en   (i_instr_en),
		.i_instr      (i_instr),
		.o_errcode    (o_errcode),
		.o_trace      (o_trace),
		.o_idle       (o_idle)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [`CPU7_WORD_W-1:0] rand_word();
		logic [63:0] r;
		r = {$urandom, $urandom};
		return r[`CPU7_WORD_W-1:0];
	endfunction

	// expected ALU result of b op a with a as the top
	function automatic logic [`CPU7_WORD_W-1:0] alu_expect(
		input logic [`CPU7_OP_W-1:0]   op,
		input logic [`CPU7_WORD_W-1:0] b,
		input logic [`CPU7_WORD_W-1:0] a
	);
		case (op)
			OP_INC: return a + `CPU7_WORD_W'(1);
			OP_DEC: return a - `CPU7_WORD_W'(1);
			OP_NOT: return ~a;
			OP_COM: return `CPU7_WORD_W'(0) - a;
			OP_ADD: return b + a;
			OP_SUB: return b - a;
			OP_AND: return b & a;
			OP_OR:  return b | a;
			OP_XOR: return b ^ a;
			OP_SHL: return b << a;
			OP_SHR: return b >> a;
			OP_EQ:  return `CPU7_WORD_W'(b == a);
			OP_NEQ: return `CPU7_WORD_W'(b != a);
			OP_GT:  return `CPU7_WORD_W'(b > a);
			OP_SM:  return `CPU7_WORD_W'(b < a);
			default: return '0;
		endcase
	endfunction

	// apply one opcode to the model and flag a fault that ends the word
	task automatic model_op(input logic [`CPU7_OP_W-1:0] op, output bit fault);
		logic [`CPU7_WORD_W-1:0] a;
		logic [`CPU7_WORD_W-1:0] b;
		logic [`CPU7_ERR_W-1:0]  code;
		int                      n;
		n    = model_q.size();
		code = `CPU7_ERR_NONE;
		a    = (n > 0) ? model_q[n-1] : '0;
		case (op)
			OP_NOP: begin
			end
			OP_DUP: begin
				if (n == 0)
					code = `CPU7_ERR_DSEMPTY;
				else if (n == `CPU7_STACK_DEPTH)
					code = `CPU7_ERR_DSFULL;
				else
					model_q.push_back(a);
			end
			OP_DROP: begin
				if (n == 0)
					code = `CPU7_ERR_DSEMPTY;
				else
					model_q.delete(n - 1);
			end
			OP_DEPTH: begin
				if (n == `CPU7_STACK_DEPTH)
					code = `CPU7_ERR_DSFULL;
				else
					model_q.push_back(`CPU7_WORD_W'(n));
			end
			OP_EMPTY: model_q.delete();
			OP_TRACE: exp_trace = (n == 0) ? 8'hff : a[7:0];	// empty gives all ones
			OP_INC, OP_DEC, OP_NOT, OP_COM: begin
				if (n == 0)
					code = `CPU7_ERR_DSEMPTY;
				else
					model_q[n-1] = alu_expect(op, '0, a);
			end
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR,
			OP_EQ, OP_NEQ, OP_GT, OP_SM: begin
				if (n < 2) begin
					code = `CPU7_ERR_DSEMPTY;
				end else begin
					b = model_q[n-2];
					model_q.delete(n - 1);
					model_q[n-2] = alu_expect(op, b, a);	// two pops and one push
				end
			end
			default: code = `CPU7_ERR_INVALID;
		endcase
		fault = (code != `CPU7_ERR_NONE);
		if (fault)
			exp_err = code;	// held until the next fault or reset
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (!o_idle && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!o_idle) begin
			$display("timeout: o_idle stayed low for %0d cycles at time %0t", TIMEOUT, $time);
			timeouts++;
		end
	endtask

	task automatic check_outputs();
		if (timeouts != 0)
			return;
		checks++;
		assert (o_trace == exp_trace) else begin
			$display("mismatch at time %0t: o_trace got %h expected %h",
				$time, o_trace, exp_trace);
			mismatches++;
		end
		assert (o_errcode == exp_err) else begin
			$display("mismatch at time %0t: o_errcode got %h expected %h",
				$time, o_errcode, exp_err);
			mismatches++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		model_q.delete();
		exp_trace = 8'hff;
		exp_err   = `CPU7_ERR_NONE;
		wait_idle();
		check_outputs();
	endtask

	task automatic push_value(input logic [`CPU7_WORD_W-1:0] v);
		if (timeouts != 0)
			return;
		@(posedge clk);
		i_push_value <= v;
		i_push_en    <= 1'b1;
		@(posedge clk);
		i_push_en <= 1'b0;
		wait_idle();
		if (model_q.size() == `CPU7_STACK_DEPTH)
			exp_err = `CPU7_ERR_DSFULL;
		else
			model_q.push_back(v);
		check_outputs();
	endtask

	// pause holds i_en low for that many cycles right after acceptance
	task automatic run_instr(input logic [`CPU7_OP_W-1:0] lo,
		input logic [`CPU7_OP_W-1:0] hi, input int pause = 0);
		bit fault;
		if (timeouts != 0)
			return;
		@(posedge clk);
		i_instr    <= '{op_hi: hi, op_lo: lo};
		i_instr_en <= 1'b1;
		@(posedge clk);
		i_instr_en <= 1'b0;
		if (pause > 0) begin
			i_en <= 1'b0;
			repeat (pause) @(posedge clk);
			i_en <= 1'b1;
		end
		wait_idle();
		model_op(lo, fault);
		if (!fault)
			model_op(hi, fault);	// a fault abandons the high opcode
		check_outputs();
	endtask

	initial begin : stimulus
		logic [`CPU7_OP_W-1:0]   bin_ops [11];
		logic [`CPU7_OP_W-1:0]   un_ops [4];
		logic [`CPU7_WORD_W-1:0] a;
		logic [`CPU7_WORD_W-1:0] b;
		int                      k;
		int                      rep;
		rst_n        = 1'b0;
		i_en         = 1'b1;
		i_push_en    = 1'b0;
		i_push_value = '0;
		i_instr_en   = 1'b0;
		i_instr      = '0;
		checks       = 0;
		mismatches   = 0;
		timeouts     = 0;
		bin_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR,
			OP_EQ, OP_NEQ, OP_GT, OP_SM};
		un_ops  = '{OP_INC, OP_DEC, OP_NOT, OP_COM};
		void'($urandom(32'hd982_9620));
		apply_reset();

		// trace the empty stack and then each push
		run_instr(OP_TRACE, OP_NOP);
		for (k = 0; k < 4; k++) begin
			push_value(rand_word());
			run_instr(OP_TRACE, OP_NOP);
		end
		run_instr(OP_EMPTY, OP_TRACE);

		// binary opcodes on random pairs and then on equal operands
		for (k = 0; k < 11; k++) begin
			for (rep = 0; rep < 2; rep++) begin
				b = rand_word();
				a = (rep == 1) ? b : rand_word();
				if (bin_ops[k] == OP_SHL || bin_ops[k] == OP_SHR)
					a = `CPU7_WORD_W'($urandom_range(60, 0));	// usable shift count
				push_value(b);
				push_value(a);
				run_instr(bin_ops[k], OP_TRACE);
				run_instr(OP_DROP, OP_NOP);
			end
		end

		// unary and stack handling
		push_value(rand_word());
		for (k = 0; k < 4; k++)
			run_instr(un_ops[k], OP_TRACE);
		run_instr(OP_DUP, OP_TRACE);
		run_instr(OP_DEPTH, OP_TRACE);
		run_instr(OP_DROP, OP_TRACE);
		run_instr(OP_DROP, OP_TRACE);
		run_instr(OP_EMPTY, OP_TRACE);
		run_instr(OP_DEPTH, OP_TRACE);

		// faults each start from a fresh reset
		apply_reset();
		for (k = 0; k < `CPU7_STACK_DEPTH + 1; k++)
			push_value(rand_word());
		apply_reset();
		run_instr(OP_DROP, OP_DEPTH);
		run_instr(OP_DEPTH, OP_TRACE);	// depth still zero
		apply_reset();
		push_value(56'h12_3456_789a_bc5a);
		run_instr(7'h7f, OP_TRACE);

		// strobe while disabled is ignored
		if (timeouts == 0) begin
			@(posedge clk);
			i_en         <= 1'b0;
			i_push_value <= rand_word();
			i_push_en    <= 1'b1;
			repeat (4) @(posedge clk);
			i_push_en <= 1'b0;
			@(posedge clk);
			i_en <= 1'b1;
			wait_idle();
			check_outputs();
		end
		run_instr(OP_DEPTH, OP_TRACE);
		push_value(56'h3c_0000_0000_00a7);
		run_instr(OP_INC, OP_TRACE, 12);	// frozen longer than the whole word takes

		$display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			checks, mismatches, timeouts, DUT.u_assert.fail_count);
		if (mismatches == 0 && timeouts == 0 && DUT.u_assert.fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/core_alu.sv
// combinational ALU for the unary and binary opcodes

`default_nettype none

`include "cpu7_params.svh"

module core_alu (
	input  cpu7_pkg::alu_req_t       i_req,
	output logic [`CPU7_WORD_W-1:0]  o_result,
	output logic                     o_valid
);

	import cpu7_pkg::*;

	logic [`CPU7_WORD_W-1:0] a;
	logic [`CPU7_WORD_W-1:0] b;

	assign a = i_req.a;
	assign b = i_req.b;

	always_comb begin
		o_result = '0;
		o_valid  = 1'b1;
		case (i_req.op)
			// unary, on the top
			OP_INC: o_result = a + 1'b1;
			OP_DEC: o_result = a - 1'b1;
			OP_NOT: o_result = ~a;
			OP_COM: o_result = ~a + 1'b1;	// two's complement negate
			// binary, b op a
			OP_ADD: o_result = b + a;
			OP_SUB: o_result = b - a;
			OP_AND: o_result = b & a;
			OP_OR:  o_result = b | a;
			OP_XOR: o_result = b ^ a;
			OP_SHL: o_result = b << a;	// a is the shift count
			OP_SHR: o_result = b >> a;
			// unsigned compares give 1 or 0
			OP_EQ:  o_result = `CPU7_WORD_W'(b == a);
			OP_NEQ: o_result = `CPU7_WORD_W'(b != a);
			OP_GT:  o_result = `CPU7_WORD_W'(b > a);
			OP_SM:  o_result = `CPU7_WORD_W'(b < a);
			default: begin
				o_valid = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/core_seq.sv
// instruction sequencer FSM driving the data stack, error code and trace output

`default_nettype none

`include "cpu7_params.svh"

module core_seq (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     i_en,
	input  logic                     i_push_en,
	input  logic [`CPU7_WORD_W-1:0]  i_push_value,
	input  logic                     i_instr_en,
	input  cpu7_pkg::instr_pair_t    i_instr,
	input  cpu7_pkg::stack_stat_t    i_stat,
	input  logic [`CPU7_WORD_W-1:0]  i_alu_result,
	input  logic                     i_alu_valid,
	output cpu7_pkg::stack_cmd_t     o_cmd,
	output cpu7_pkg::alu_req_t       o_alu,
	output cpu7_pkg::errcode_t       o_errcode,
	output logic [7:0]               o_trace,
	output logic                     o_idle
);

	import cpu7_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE, S_CHECK, S_PUSH, S_POP, S_PEEK, S_POKE, S_EXEC, S_OP_DONE
	} state_t;

	state_t                  state;
	state_t                  ret_state;	// where a stack phase continues
	instr_pair_t             instr_r;
	opcode_t                 cur_op;
	logic                    second;	// running the high opcode
	logic [1:0]              step;
	logic [`CPU7_WORD_W-1:0] opa;
	logic [`CPU7_WORD_W-1:0] opb;
	logic [`CPU7_WORD_W-1:0] data_r;	// value to push or poke

	function automatic logic is_unary(opcode_t op);
		return (op == OP_INC) || (op == OP_DEC) || (op == OP_NOT) || (op == OP_COM);
	endfunction

	function automatic logic is_binary(opcode_t op);
		case (op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR,
			OP_EQ, OP_NEQ, OP_GT, OP_SM: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// strobes fire in the phase cycle itself, so the stack acts on the same edge
	assign o_cmd.push  = i_en && (state == S_PUSH) && !i_stat.full;
	assign o_cmd.pop   = i_en && (state == S_POP) && !i_stat.empty;
	assign o_cmd.peek  = i_en && (state == S_PEEK) && !i_stat.empty;
	assign o_cmd.poke  = i_en && (state == S_POKE);
	assign o_cmd.clear = i_en && (state == S_CHECK) && (cur_op == OP_EMPTY);
	assign o_cmd.idx   = '0;	// every access is at the top
	assign o_cmd.data  = data_r;

	assign o_alu = '{op: cur_op, a: opa, b: opb};

	assign o_idle = (state == S_IDLE) && !i_push_en && !i_instr_en;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			second    <= 1'b0;
			step      <= '0;
			o_errcode <= ERR_NONE;
			o_trace   <= '1;
		end else if (i_en) begin
			case (state)
				S_IDLE: begin
					if (i_push_en) begin
						data_r    <= i_push_value;
						ret_state <= S_IDLE;
						state     <= S_PUSH;
					end else if (i_instr_en) begin
						instr_r <= i_instr;
						cur_op  <= opcode_t'(i_instr.op_lo);
						second  <= 1'b0;
						state   <= S_CHECK;
					end
				end
				S_CHECK: begin
					step      <= '0;
					ret_state <= S_EXEC;
					if (cur_op == OP_NOP || cur_op == OP_EMPTY) begin
						state <= S_OP_DONE;	// clear strobe already out for EMPTY
					end else if (cur_op == OP_DROP) begin
						ret_state <= S_OP_DONE;
						state     <= S_POP;
					end else if (cur_op == OP_DEPTH) begin
						data_r    <= {{(`CPU7_WORD_W-`CPU7_IDX_W){1'b0}}, i_stat.depth};
						ret_state <= S_OP_DONE;
						state     <= S_PUSH;
					end else if (cur_op == OP_TRACE && i_stat.empty) begin
						o_trace <= '1;
						state   <= S_OP_DONE;
					end else if (cur_op == OP_DUP || cur_op == OP_TRACE || is_unary(cur_op)) begin
						state <= S_PEEK;
					end else if (is_binary(cur_op)) begin
						if (i_stat.depth < `CPU7_IDX_W'(2)) begin
							o_errcode <= ERR_DSEMPTY;
							state     <= S_IDLE;
						end else begin
							state <= S_POP;
						end
					end else begin
						o_errcode <= ERR_INVALID;
						state     <= S_IDLE;
					end
				end
				S_PUSH: begin
					if (i_stat.full) begin
						o_errcode <= ERR_DSFULL;
						state     <= S_IDLE;
					end else begin
						state <= ret_state;
					end
				end
				S_POP, S_PEEK, S_POKE: begin
					if (state != S_POKE && i_stat.empty) begin
						o_errcode <= ERR_DSEMPTY;
						state     <= S_IDLE;
					end else begin
						state <= ret_state;
					end
				end
				S_EXEC: begin
					// stack data out holds the item fetched by the previous phase
					if (cur_op == OP_TRACE) begin
						o_trace <= i_stat.data[7:0];
						state   <= S_OP_DONE;
					end else if (cur_op == OP_DUP) begin
						data_r    <= i_stat.data;
						ret_state <= S_OP_DONE;
						state     <= S_PUSH;
					end else if (step == 2'd0) begin
						opa  <= i_stat.data;
						step <= is_unary(cur_op) ? 2'd2 : 2'd1;
						if (!is_unary(cur_op))
							state <= S_POP;	// second operand
					end else if (step == 2'd1) begin
						opb  <= i_stat.data;
						step <= 2'd2;
					end else if (!i_alu_valid) begin
						o_errcode <= ERR_INVALID;
						state     <= S_IDLE;
					end else begin
						data_r    <= i_alu_result;
						ret_state <= S_OP_DONE;
						state     <= is_unary(cur_op) ? S_POKE : S_PUSH;
					end
				end
				S_OP_DONE: begin
					if (!second) begin
						second <= 1'b1;
						cur_op <= opcode_t'(instr_r.op_hi);
						state  <= S_CHECK;
					end else begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/cpu7_core.sv
// cpu7 core top joining the sequencer, ALU and data stack

`default_nettype none

`include "cpu7_params.svh"

module cpu7_core (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     i_en,
	input  logic                     i_push_en,
	input  logic [`CPU7_WORD_W-1:0]  i_push_value,
	input  logic                     i_instr_en,
	input  cpu7_pkg::instr_pair_t    i_instr,
	output cpu7_pkg::errcode_t       o_errcode,
	output logic [7:0]               o_trace,
	output logic                     o_idle
);

	import cpu7_pkg::*;

	stack_cmd_t              stack_cmd;
	stack_stat_t             stack_stat;
	alu_req_t                alu_req;
	logic [`CPU7_WORD_W-1:0] alu_result;
	logic                    alu_valid;

	core_seq u_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_en         (i_en),
		.i_push_en    (i_push_en),
		.i_push_value (i_push_value),
		.i_instr_en   (i_instr_en),
		.i_instr      (i_instr),
		.i_stat       (stack_stat),
		.i_alu_result (alu_result),
		.i_alu_valid  (alu_valid),
		.o_cmd        (stack_cmd),
		.o_alu        (alu_req),
		.o_errcode    (o_errcode),
		.o_trace      (o_trace),
		.o_idle       (o_idle)
	);

	core_alu u_alu (
		.i_req    (alu_req),
		.o_result (alu_result),
		.o_valid  (alu_valid)
	);

	data_stack u_stack (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_cmd  (stack_cmd),
		.o_stat (stack_stat)
	);

endmodule

`default_nettype wire

//--- src/cpu7_params.svh
// data widths, stack depth, opcode codes and error codes for the cpu7 core
`ifndef CPU7_PARAMS_SVH
`define CPU7_PARAMS_SVH

`define CPU7_WORD_W      56	// data stack word
`define CPU7_OP_W        7	// one opcode, two per instruction word
`define CPU7_STACK_DEPTH 8
`define CPU7_IDX_W       4	// holds 0..depth, one bit over the address
`define CPU7_ERR_W       9

// stack handling
`define CPU7_OP_NOP   7'h00
`define CPU7_OP_DUP   7'h01
`define CPU7_OP_DROP  7'h02
`define CPU7_OP_DEPTH 7'h03
`define CPU7_OP_EMPTY 7'h04
`define CPU7_OP_TRACE 7'h05

// unary group
`define CPU7_OP_INC 7'h10
`define CPU7_OP_DEC 7'h11
`define CPU7_OP_NOT 7'h12
`define CPU7_OP_COM 7'h13

// binary group, evaluated as second op top
`define CPU7_OP_ADD 7'h20
`define CPU7_OP_SUB 7'h21
`define CPU7_OP_AND 7'h22
`define CPU7_OP_OR  7'h23
`define CPU7_OP_XOR 7'h24
`define CPU7_OP_SHL 7'h25
`define CPU7_OP_SHR 7'h26
`define CPU7_OP_EQ  7'h27
`define CPU7_OP_NEQ 7'h28
`define CPU7_OP_GT  7'h29
`define CPU7_OP_SM  7'h2a

`define CPU7_ERR_NONE    9'h000
`define CPU7_ERR_DSFULL  9'h001
`define CPU7_ERR_DSEMPTY 9'h002
`define CPU7_ERR_DSINDEX 9'h003
`define CPU7_ERR_INVALID 9'h004

`endif

//--- src/cpu7_pkg.sv
// opcode and error enums, instruction word, stack and ALU structs

`default_nettype none

`include "cpu7_params.svh"

package cpu7_pkg;

	typedef enum logic [`CPU7_OP_W-1:0] {
		OP_NOP   = `CPU7_OP_NOP,
		OP_DUP   = `CPU7_OP_DUP,
		OP_DROP  = `CPU7_OP_DROP,
		OP_DEPTH = `CPU7_OP_DEPTH,
		OP_EMPTY = `CPU7_OP_EMPTY,
		OP_TRACE = `CPU7_OP_TRACE,
		OP_INC   = `CPU7_OP_INC,
		OP_DEC   = `CPU7_OP_DEC,
		OP_NOT   = `CPU7_OP_NOT,
		OP_COM   = `CPU7_OP_COM,
		OP_ADD   = `CPU7_OP_ADD,
		OP_SUB   = `CPU7_OP_SUB,
		OP_AND   = `CPU7_OP_AND,
		OP_OR    = `CPU7_OP_OR,
		OP_XOR   = `CPU7_OP_XOR,
		OP_SHL   = `CPU7_OP_SHL,
		OP_SHR   = `CPU7_OP_SHR,
		OP_EQ    = `CPU7_OP_EQ,
		OP_NEQ   = `CPU7_OP_NEQ,
		OP_GT    = `CPU7_OP_GT,
		OP_SM    = `CPU7_OP_SM
	} opcode_t;

	typedef enum logic [`CPU7_ERR_W-1:0] {
		ERR_NONE    = `CPU7_ERR_NONE,
		ERR_DSFULL  = `CPU7_ERR_DSFULL,
		ERR_DSEMPTY = `CPU7_ERR_DSEMPTY,
		ERR_DSINDEX = `CPU7_ERR_DSINDEX,
		ERR_INVALID = `CPU7_ERR_INVALID
	} errcode_t;

	// low opcode runs first
	typedef struct packed {
		logic [`CPU7_OP_W-1:0] op_hi;
		logic [`CPU7_OP_W-1:0] op_lo;
	} instr_pair_t;

	typedef struct packed {
		logic                    push;
		logic                    pop;
		logic                    peek;
		logic                    poke;
		logic                    clear;
		logic [`CPU7_IDX_W-1:0]  idx;	// counted from the top, 0 is top
		logic [`CPU7_WORD_W-1:0] data;
	} stack_cmd_t;

	typedef struct packed {
		logic                    full;
		logic                    empty;
		logic [`CPU7_IDX_W-1:0]  depth;
		logic [`CPU7_WORD_W-1:0] data;	// result of the last pop or peek
	} stack_stat_t;

	typedef struct packed {
		opcode_t                 op;
		logic [`CPU7_WORD_W-1:0] a;	// stack top
		logic [`CPU7_WORD_W-1:0] b;	// item below the top
	} alu_req_t;

endpackage

`default_nettype wire

//--- src/data_stack.sv
// data stack LIFO with push, pop, indexed peek and poke, and clear

`default_nettype none

`include "cpu7_params.svh"

module data_stack (
	input  logic                  clk,
	input  logic                  rst_n,
	input  cpu7_pkg::stack_cmd_t  i_cmd,
	output cpu7_pkg::stack_stat_t o_stat
);

	localparam int PTR_W = $clog2(`CPU7_STACK_DEPTH);

	logic [`CPU7_WORD_W-1:0] mem [`CPU7_STACK_DEPTH];
	logic [`CPU7_IDX_W-1:0]  count;	// items held
	logic [`CPU7_IDX_W-1:0]  top;	// slot of the top item
	logic [`CPU7_IDX_W-1:0]  at;	// slot addressed by peek or poke
	logic [`CPU7_WORD_W-1:0] dout;

	assign top = count - 1'b1;
	assign at  = top - i_cmd.idx;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (i_cmd.clear) begin
			count <= '0;	// one cycle, contents left stale
		end else if (i_cmd.push) begin
			count <= count + 1'b1;
		end else if (i_cmd.pop) begin
			count <= count - 1'b1;
		end
	end

	// storage and read port
	always_ff @(posedge clk) begin
		if (i_cmd.push)
			mem[count[PTR_W-1:0]] <= i_cmd.data;	// just above the top
		if (i_cmd.poke)
			mem[at[PTR_W-1:0]] <= i_cmd.data;
		if (i_cmd.pop)
			dout <= mem[top[PTR_W-1:0]];
		if (i_cmd.peek)
			dout <= mem[at[PTR_W-1:0]];
	end

	assign o_stat.full  = (count == `CPU7_IDX_W'(`CPU7_STACK_DEPTH));
	assign o_stat.empty = (count == '0);
	assign o_stat.depth = count;
	assign o_stat.data  = dout;

endmodule

`default_nettype wire
